// ==== dv/dac_chain_model.sv ====
`timescale 1ns/1ps
// DAC side model, resolves the MOSI pin and captures SPI frames

module dac_chain_model (
    input  logic sclk,
    input  logic csel,
    input  logic mosi,
    input  logic mosi_en,
    input  logic pull_level,                    // level held by the DAC side on a floating pin
    output logic mosi_read                      // resolved pin level
);

    // ------------------------------------------------------------------------
    // captured frames, {bit count, data} with the last bit in data[0]
    // ------------------------------------------------------------------------
    logic [135:0] frame_q [$];                  // oldest frame first
    logic [127:0] shift_in = '0;
    logic [7:0]   bit_cnt  = '0;                // a full chain frame is 128 bits

    // pin is driven only once the type test is over
    assign mosi_read = mosi_en ? mosi : pull_level;

    // DACs sample on rising sclk while selected, frame closes on csel rise
    always @(posedge sclk or posedge csel) begin
        if (csel) begin
            if (bit_cnt != 8'd0) begin
                frame_q.push_back({bit_cnt, shift_in});
            end
            shift_in = '0;                      // ready for the next frame
            bit_cnt  = '0;
        end else begin
            shift_in = {shift_in[126:0], mosi_read};
            bit_cnt  = bit_cnt + 8'd1;
        end
    end

endmodule

// ==== dv/dac_ctrl_tb.sv ====
`timescale 1ns/1ps
// testbench top for the servo DAC controller
// clock, reset, LFSR set-points, directed tests and cycle limit

module dac_ctrl_tb;

    localparam int cycle_limit = 6000;          // 8 transactions of ~600 cycles plus margin

    // fixed set-points for the chain and quad framing tests
    localparam dac_pkg::dac_set_t fixed_set = '{
        ch3: 16'hc3a5, ch2: 16'h2b71, ch1: 16'hf00d, ch0: 16'h0412
    };

    logic              sysclk = 1'b0;
    logic              dac_test_reset;
    dac_pkg::dac_set_t dac_set;
    logic              data_ready;
    logic              pull_level;              // pin level while MOSI floats
    logic              mosi_read;
    logic              sclk;
    logic              mosi;
    logic              mosi_en;
    logic              csel;
    logic              busy;
    logic              quad_dac;
    int                error_cnt;
    int                cycle_cnt;
    logic [15:0]       lfsr_state;

    dac_ctrl_top #(
        .sclk_half      (2)
    ) dac_ctrl_top_i (
        .sysclk         (sysclk),
        .dac_test_reset (dac_test_reset),
        .dac_set        (dac_set),
        .data_ready     (data_ready),
        .mosi_read      (mosi_read),
        .sclk           (sclk),
        .mosi           (mosi),
        .mosi_en        (mosi_en),
        .csel           (csel),
        .busy           (busy),
        .quad_dac       (quad_dac)
    );

    dac_chain_model model_i (
        .sclk       (sclk),
        .csel       (csel),
        .mosi       (mosi),
        .mosi_en    (mosi_en),
        .pull_level (pull_level),
        .mosi_read  (mosi_read)
    );

    // ------------------------------------------------------------------------
    // clock and cycle limit
    // ------------------------------------------------------------------------
    initial begin
        forever #10 sysclk = ~sysclk;           // 20 ns period
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge sysclk);
            cycle_cnt++;
            if (cycle_cnt >= cycle_limit) begin
                $display("timeout, the tests did not finish within %0d cycles", cycle_limit);
                $display("Test failures found");
                $fatal(1, "simulation stopped on timeout");
            end
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // write-and-update word with pad 0, cmd 3, channel address and code
    function automatic logic [31:0] expected_word(input int ch, input logic [15:0] val);
        return {8'h00, 4'h3, 4'(ch), val};
    endfunction

    function automatic logic [15:0] channel_value(input dac_pkg::dac_set_t s, input int ch);
        case (ch)
            0:       return s.ch0;
            1:       return s.ch1;
            2:       return s.ch2;
            default: return s.ch3;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            error_cnt++;
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // reset with the pull level of the wanted DAC kind and check the sensed kind
    task automatic select_dac_kind(input string name, input logic quad);
        pull_level = ~quad;                     // quad part pulls MOSI low
        dac_test_reset = 1'b1;
        repeat (2) @(negedge sysclk);
        dac_test_reset = 1'b0;
        @(negedge sysclk);                      // type test samples here
        check_value({name, " dac kind"}, quad, quad_dac);
    endtask

    task automatic strobe_set(input dac_pkg::dac_set_t s);
        dac_set    = s;
        data_ready = 1'b1;
        @(negedge sysclk);
        data_ready = 1'b0;
    endtask

    task automatic run_transaction(input dac_pkg::dac_set_t s);
        strobe_set(s);
        while (!busy) @(negedge sysclk);
        while (busy) @(negedge sysclk);         // ends one cycle after last csel rise
    endtask

    // one LFSR step per bit taken
    task automatic random_set(output dac_pkg::dac_set_t s);
        logic [63:0] bits;
        for (int b = 0; b < 64; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[62:0], lfsr_state[0]};
        end
        s = bits;
    endtask

    // compare captured frames with the words of one set in the given framing
    task automatic check_frames(input string name, input logic quad,
                                input dac_pkg::dac_set_t s);
        logic [135:0] frame;
        logic [127:0] chain_exp;
        if (quad) begin
            check_value({name, " frame count"}, 4, model_i.frame_q.size());
            for (int ch = 0; ch < dac_pkg::num_channels; ch++) begin
                frame = model_i.frame_q.pop_front();
                check_value({name, " bit count"}, 32, frame[135:128]);
                check_value(name, expected_word(ch, channel_value(s, ch)), frame[31:0]);
            end
        end else begin
            // word 3 goes out first and lands in the far DAC
            chain_exp = {expected_word(3, s.ch3), expected_word(2, s.ch2),
                         expected_word(1, s.ch1), expected_word(0, s.ch0)};
            check_value({name, " frame count"}, 1, model_i.frame_q.size());
            frame = model_i.frame_q.pop_front();
            check_value({name, " bit count"}, 128, frame[135:128]);
            check_value(name, chain_exp, frame[127:0]);
        end
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic reset_state();
        @(negedge sysclk);                      // one clock into reset
        check_value("reset_state csel", 1, csel);
        check_value("reset_state sclk", 0, sclk);
        check_value("reset_state busy", 0, busy);
        check_value("reset_state mosi_en", 0, mosi_en);
        @(negedge sysclk);
        dac_test_reset = 1'b0;
        check_value("reset_state mosi_en", 0, mosi_en);  // no clock out of reset yet
        @(negedge sysclk);
        check_value("reset_state mosi_en", 1, mosi_en);
        check_value("reset_state csel", 1, csel);
        check_value("reset_state sclk", 0, sclk);
        check_value("reset_state busy", 0, busy);
    endtask

    task automatic type_detect();
        check_value("type_detect chain", 0, quad_dac);   // pull high since start
        select_dac_kind("type_detect", 1'b1);
    endtask

    task automatic chain_frame();
        int lat;
        select_dac_kind("chain_frame", 1'b0);
        strobe_set(fixed_set);
        lat = 1;                                // the strobe cycle itself
        while (csel) begin
            @(negedge sysclk);
            lat++;
        end
        check_value("chain_frame latency", 3, lat);
        while (busy) @(negedge sysclk);
        check_frames("chain_frame", 1'b0, fixed_set);
    endtask

    task automatic quad_frames();
        select_dac_kind("quad_frames", 1'b1);
        run_transaction(fixed_set);
        check_frames("quad_frames", 1'b1, fixed_set);
    endtask

    task automatic busy_drop();
        dac_pkg::dac_set_t first_set;
        dac_pkg::dac_set_t late_set;
        dac_pkg::dac_set_t next_set;
        first_set = '{ch3: 16'h0101, ch2: 16'h0202, ch1: 16'h0303, ch0: 16'h0404};
        late_set  = '{ch3: 16'hdead, ch2: 16'hbeef, ch1: 16'h5555, ch0: 16'haaaa};
        next_set  = '{ch3: 16'h7fff, ch2: 16'h8001, ch1: 16'h0000, ch0: 16'hffff};
        strobe_set(first_set);
        while (!busy) @(negedge sysclk);
        repeat (20) @(negedge sysclk);
        check_value("busy_drop busy", 1, busy);
        strobe_set(late_set);                   // must be dropped
        while (busy) @(negedge sysclk);
        repeat (10) @(negedge sysclk);
        check_value("busy_drop restart", 0, busy);
        check_frames("busy_drop first", 1'b1, first_set);
        run_transaction(next_set);
        check_frames("busy_drop third", 1'b1, next_set);
    endtask

    task automatic random_values();
        dac_pkg::dac_set_t s;
        for (int i = 0; i < 4; i++) begin
            select_dac_kind("random_values", i[0]);     // alternate chain and quad
            random_set(s);
            run_transaction(s);
            check_value("random_values csel", 1, csel);  // deselected before busy drops
            check_frames("random_values", i[0], s);
        end
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        dac_test_reset = 1'b1;                  // held for the first 2 cycles
        dac_set        = '0;
        data_ready     = 1'b0;
        pull_level     = 1'b1;
        error_cnt      = 0;
        lfsr_state     = 16'd92;

        reset_state();
        type_detect();
        chain_frame();
        quad_frames();
        busy_drop();
        random_values();

        if (error_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== logic/dac_cmd_regs.sv ====
`timescale 1ns/1ps
// command word register file for the servo DACs
// trig generation, NOP flush of used words, one-shot DAC type test

module dac_cmd_regs (
    input  logic               sysclk,
    input  logic               dac_test_reset,  // also restarts the type test
    input  dac_pkg::dac_set_t  dac_set,         // set-points from host side
    input  logic               data_ready,      // one-cycle strobe, new set-points
    input  logic               busy,            // SPI engine busy
    input  logic               flush,           // word at word_addr was loaded
    input  dac_pkg::dac_addr_t word_addr,       // word requested by SPI engine
    input  logic               mosi_read,       // sensed MOSI pin level
    output logic               trig,            // start request, held until busy
    output dac_pkg::dac_word_t word,            // selected command word
    output logic               quad_dac,        // 1 = one quad part, 0 = chain of singles
    output logic               test_done        // type test finished, MOSI may be driven
);

    // NOP word, written back to each entry once the SPI engine has taken it
    localparam dac_pkg::dac_word_t nop_word = '{
        pad:   8'h00,
        cmd:   dac_pkg::cmd_nop,
        addr:  4'h0,
        value: dac_pkg::dac_val_init
    };

    dac_pkg::dac_word_t words [dac_pkg::num_channels];  // one entry per channel

    // write-and-update word for one channel
    function automatic dac_pkg::dac_word_t wru_word(
        input logic [3:0]          ch,
        input dac_pkg::dac_value_t val
    );
        dac_pkg::dac_word_t w;
        w.pad   = 8'h00;
        w.cmd   = dac_pkg::cmd_wru;
        w.addr  = ch;
        w.value = val;
        return w;
    endfunction

    logic accept;                               // strobe taken this cycle

    assign accept = data_ready && !busy;        // writes while busy are dropped
    assign word   = words[word_addr];           // combinational read port

    // ------------------------------------------------------------------------
    // DAC type test
    // ------------------------------------------------------------------------
    // MOSI is left floating until test_done, the quad part pulls it low
    always_ff @(posedge sysclk) begin
        if (dac_test_reset) begin
            test_done <= 1'b0;
            quad_dac  <= 1'b0;
        end else if (!test_done) begin
            test_done <= 1'b1;                  // one sample, first clock out of reset
            quad_dac  <= ~mosi_read;            // low level means quad part
        end
    end

    // ------------------------------------------------------------------------
    // trig handshake
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (dac_test_reset) begin
            trig <= 1'b0;
        end else if (accept) begin
            trig <= 1'b1;                       // rises the clock after the strobe
        end else if (trig && busy) begin
            trig <= 1'b0;                       // SPI engine has picked it up
        end
    end

    // ------------------------------------------------------------------------
    // command word entries
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (dac_test_reset) begin
            for (int i = 0; i < dac_pkg::num_channels; i++) begin
                words[i] <= nop_word;           // never send a stale word
            end
        end else if (accept) begin
            // all four channels rewritten on every transaction
            words[0] <= wru_word(4'd0, dac_set.ch0);
            words[1] <= wru_word(4'd1, dac_set.ch1);
            words[2] <= wru_word(4'd2, dac_set.ch2);
            words[3] <= wru_word(4'd3, dac_set.ch3);
        end else if (flush) begin
            words[word_addr] <= nop_word;       // used up, back to NOP
        end
    end

endmodule

// ==== logic/dac_ctrl_top.sv ====
`timescale 1ns/1ps
// servo DAC controller top, register file plus SPI engine

module dac_ctrl_top #(
    parameter int sclk_half = 4                 // sclk half period in sysclk cycles
) (
    input  logic              sysclk,
    input  logic              dac_test_reset,   // sync, active high
    input  dac_pkg::dac_set_t dac_set,          // four set-points from host
    input  logic              data_ready,       // strobe for dac_set
    input  logic              mosi_read,        // sensed MOSI pin
    output logic              sclk,
    output logic              mosi,
    output logic              mosi_en,          // MOSI driver enable, off during type test
    output logic              csel,
    output logic              busy,
    output logic              quad_dac          // sensed DAC kind
);

    logic               trig;                   // regs -> spi, start request
    logic               flush;                  // spi -> regs, clear loaded word
    logic               test_done;              // type test finished
    dac_pkg::dac_addr_t word_addr;
    dac_pkg::dac_word_t word;

    assign mosi_en = test_done;                 // pin floats until sensed

    dac_cmd_regs dac_cmd_regs_i (
        .sysclk         (sysclk),
        .dac_test_reset (dac_test_reset),
        .dac_set        (dac_set),
        .data_ready     (data_ready),
        .busy           (busy),
        .flush          (flush),
        .word_addr      (word_addr),
        .mosi_read      (mosi_read),
        .trig           (trig),
        .word           (word),
        .quad_dac       (quad_dac),
        .test_done      (test_done)
    );

    dac_spi_chain #(
        .sclk_half      (sclk_half)
    ) dac_spi_chain_i (
        .sysclk         (sysclk),
        .dac_test_reset (dac_test_reset),
        .trig           (trig),
        .word           (word),
        .quad_dac       (quad_dac),
        .test_done      (test_done),
        .word_addr      (word_addr),
        .flush          (flush),
        .busy           (busy),
        .sclk           (sclk),
        .csel           (csel),
        .mosi           (mosi)
    );

endmodule

// ==== logic/dac_pkg.sv ====
// shared types for the servo DAC controller
// widths, command word layout, set-point bundle, DAC commands, SPI states

package dac_pkg;

    // ------------------------------------------------------------------------
    // board level constants
    // ------------------------------------------------------------------------
    localparam int num_channels = 4;        // servo DAC channels on the board

    typedef logic [15:0] dac_value_t;       // raw DAC code, mid-scale is zero output
    typedef logic [1:0]  dac_addr_t;        // channel / word index

    // DAC command codes, top nibble of the second byte of the word
    typedef enum logic [3:0] {
        cmd_wru = 4'h3,                     // write input register and update output
        cmd_nop = 4'hf                      // no operation, DAC ignores the word
    } dac_cmd_t;

    localparam dac_value_t dac_val_init = 16'h8000;  // mid-scale code for NOP words

    // ------------------------------------------------------------------------
    // 32-bit command word as clocked out on SPI, MSB first
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [7:0] pad;                    // don't care bits, always sent as zero
        dac_cmd_t   cmd;                    // command nibble
        logic [3:0] addr;                   // channel number
        dac_value_t value;                  // 16-bit DAC code
    } dac_word_t;

    // host set-points, all four channels written together
    typedef struct packed {
        dac_value_t ch3;
        dac_value_t ch2;
        dac_value_t ch1;
        dac_value_t ch0;
    } dac_set_t;

    // SPI engine FSM
    typedef enum logic [1:0] {
        idle,                               // csel high, waiting on trig
        sel,                                // csel falls, first word loaded
        shift,                              // clocking bits out
        desel                               // csel rise and inter-frame gap
    } spi_state_t;

endpackage

// ==== logic/dac_spi_chain.sv ====
`timescale 1ns/1ps
// SPI engine for the servo DACs
// sclk divider, 32-bit shifter, chain or quad framing, flush strobes

module dac_spi_chain #(
    parameter int sclk_half = 4                 // sysclk cycles per sclk half period
) (
    input  logic               sysclk,
    input  logic               dac_test_reset,
    input  logic               trig,            // start request from register file
    input  dac_pkg::dac_word_t word,            // word at word_addr
    input  logic               quad_dac,        // framing select
    input  logic               test_done,       // no transaction before type test
    output dac_pkg::dac_addr_t word_addr,       // word wanted from register file
    output logic               flush,           // loaded word becomes NOP
    output logic               busy,
    output logic               sclk,            // idles low
    output logic               csel,            // active low chip select
    output logic               mosi             // MSB first, changes while sclk low
);

    // counter must also reach the 2 x sclk_half gap between quad frames
    localparam int cnt_w = $clog2(2 * sclk_half + 1);

    typedef logic [cnt_w-1:0] half_cnt_t;

    localparam half_cnt_t half_last = half_cnt_t'(sclk_half - 1);      // end of half period
    localparam half_cnt_t gap_last  = half_cnt_t'(2 * sclk_half - 2);  // gap before next sel

    dac_pkg::spi_state_t state;
    half_cnt_t           half_cnt;              // sysclk count within half period
    logic [4:0]          bit_cnt;               // bit within current word
    logic [2:0]          word_cnt;              // next word to load, 4 = all taken
    logic [31:0]         shreg;                 // output shifter

    logic half_end;                             // last cycle of a half period
    logic words_done;                           // all four words loaded
    logic last_word;                            // word in shifter closes the frame

    assign half_end   = (half_cnt == half_last);
    assign words_done = (word_cnt == 3'd4);
    assign last_word  = quad_dac || words_done; // quad part takes one word per frame

    // chain sends 3,2,1,0 so word 3 ends up in the far DAC, quad sends 0..3
    assign word_addr = quad_dac ? word_cnt[1:0] : ~word_cnt[1:0];
    assign mosi      = shreg[31];

    // ------------------------------------------------------------------------
    // FSM, sclk and csel generation
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (dac_test_reset) begin
            state    <= dac_pkg::idle;
            busy     <= 1'b0;
            csel     <= 1'b1;
            sclk     <= 1'b0;
            flush    <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
            word_cnt <= '0;
        end else begin
            flush <= 1'b0;                      // one-cycle pulse by default
            if (flush) begin
                word_cnt <= word_cnt + 3'd1;    // step after the flushed entry is cleared
            end

            case (state)
                dac_pkg::idle: begin
                    word_cnt <= '0;
                    if (trig && test_done) begin
                        busy  <= 1'b1;
                        state <= dac_pkg::sel;
                    end
                end

                // two cycles: csel falls with the first load, then one lead cycle
                dac_pkg::sel: begin
                    if (csel) begin
                        csel    <= 1'b0;
                        shreg   <= word;
                        flush   <= 1'b1;
                        bit_cnt <= '0;
                    end else begin
                        half_cnt <= '0;
                        state    <= dac_pkg::shift;
                    end
                end

                dac_pkg::shift: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        sclk     <= ~sclk;
                        if (sclk) begin         // falling edge, move to next bit
                            bit_cnt <= bit_cnt + 5'd1;      // wraps at word end
                            if (bit_cnt != 5'd31) begin
                                shreg <= {shreg[30:0], 1'b0};
                            end else if (last_word) begin
                                state <= dac_pkg::desel;
                            end else begin
                                shreg <= word;  // chain, next word follows directly
                                flush <= 1'b1;
                            end
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end

                dac_pkg::desel: begin
                    if (!csel) begin
                        // hold csel low one half period past the last falling edge
                        if (half_end) begin
                            csel     <= 1'b1;
                            half_cnt <= '0;
                        end else begin
                            half_cnt <= half_cnt + 1'b1;
                        end
                    end else if (words_done) begin
                        busy  <= 1'b0;          // one cycle after final csel rise
                        state <= dac_pkg::idle;
                    end else if (half_cnt == gap_last) begin
                        state <= dac_pkg::sel;  // quad, next frame
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end

                default: state <= dac_pkg::idle;
            endcase
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the servo DAC controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module dac_ctrl_tb

# pass or fail is decided by the testbench output
if ./obj_dir/Vdac_ctrl_tb | tee /dev/stderr | grep -qF "All tests passed!"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== verilog.f ====
logic/dac_pkg.sv
logic/dac_cmd_regs.sv
logic/dac_spi_chain.sv
logic/dac_ctrl_top.sv
dv/dac_chain_model.sv
dv/dac_ctrl_tb.sv
